// File: common/audio_pkg.sv
// Audio stream types

package audio_pkg;

  // -------------------------------------------------------------------------
  // sample format
  // -------------------------------------------------------------------------

  // converter word size, left aligned pcm
  localparam int sample_width = 24;

  // one audio sample as carried on every stream and in every buffer
  typedef logic [sample_width-1:0] sample_t;

  // -------------------------------------------------------------------------
  // dac stream
  // -------------------------------------------------------------------------

  // one beat towards the dac
  // a stereo frame is two beats, left first, then right with last set
  typedef struct packed {
    sample_t sample;  // pcm payload
    logic    last;    // high on the right channel beat
  } dac_beat_t;

  // the adc side has no framing of its own
  // it is a bare sample_t next to valid/ready

endpackage

// File: common/buffer_pkg.sv
// Sample buffer port types

package buffer_pkg;

  // -------------------------------------------------------------------------
  // sample memory ports
  // -------------------------------------------------------------------------

  // write port, recorder to memory
  // single cycle strobe, the memory takes it on the same edge
  typedef struct packed {
    logic               en;    // write strobe, only while memory not full
    audio_pkg::sample_t data;  // sample to store at the write pointer
  } mem_wr_t;

  // read return, memory to player
  // registered, one cycle after rd_en
  typedef struct packed {
    logic               valid;  // data holds a sample this cycle
    audio_pkg::sample_t data;   // sample from the old read pointer
  } mem_rd_t;

  // -------------------------------------------------------------------------
  // default sizes, log2 of the depth
  // -------------------------------------------------------------------------

  localparam int default_mem_addr_width  = 4;  // 16 samples of ring buffer
  localparam int default_fifo_addr_width = 2;  // 4 samples per fifo

endpackage

// File: player/sample_player.sv
// Sample player with stereo framing
`timescale 1ns/100ps

module sample_player #(
  parameter int fifo_addr_width = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // sample memory read side
  input  logic                  mem_empty,
  output logic                  rd_en,
  input  buffer_pkg::mem_rd_t   mem_rd,

  // dac stream out
  output audio_pkg::dac_beat_t  dac_beat,
  output logic                  dac_valid,
  input  logic                  dac_ready
);

  import audio_pkg::*;

  typedef logic [fifo_addr_width:0]   level_t;   // fifo fill level
  typedef logic [fifo_addr_width+1:0] commit_t;  // level plus read in flight

  typedef enum logic [1:0] {
    frame_idle,    // waiting for a full frame in the fifo
    frame_first,   // left beat on the bus
    frame_second   // right beat on the bus, last high
  } frame_state_t;

  localparam commit_t fifo_depth = commit_t'(2 ** fifo_addr_width);
  localparam level_t  one_frame  = level_t'(2);
  localparam level_t  frame_more = level_t'(3);  // a frame left after a pop

  frame_state_t state_q;
  frame_state_t state_d;

  level_t  fill_level;
  commit_t committed;
  logic    pb_pop;
  sample_t head_sample;

  // -------------------------------------------------------------------------
  // memory read request
  // -------------------------------------------------------------------------

  // mem_rd.valid is the read issued last cycle, not yet in the fifo
  assign committed = {1'b0, fill_level} + commit_t'(mem_rd.valid);

  // pops this cycle are not counted
  assign rd_en = !mem_empty && (committed < fifo_depth);

  // -------------------------------------------------------------------------
  // playback fifo
  // -------------------------------------------------------------------------
  assign pb_pop = dac_valid && dac_ready;  // one pop per dac transfer

  sync_fifo #(
    .fifo_addr_width ( fifo_addr_width )
  ) playback_fifo_i (
    .clk             ( clk             ), // input
    .rst_n           ( rst_n           ), // input

    // ingress, straight from the memory return
    .wr_en           ( mem_rd.valid    ), // input
    .wr_data         ( mem_rd.data     ), // input
    .full            (                 ), // output

    // egress
    .rd_en           ( pb_pop          ), // input
    .rd_data         ( head_sample     ), // output
    .empty           (                 ), // output

    .fill_level      ( fill_level      )  // output
  );

  // -------------------------------------------------------------------------
  // frame fsm
  // -------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      frame_idle: begin
        if (fill_level >= one_frame) state_d = frame_first;
      end
      frame_first: begin
        if (dac_ready) state_d = frame_second;
      end
      frame_second: begin
        // back to back frames when the next pair is already there
        if (dac_ready) begin
          state_d = (fill_level >= frame_more) ? frame_first : frame_idle;
        end
      end
      default: state_d = frame_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= frame_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // head holds still until its transfer, so valid data stays stable
  assign dac_valid       = state_q != frame_idle;
  assign dac_beat.sample = head_sample;
  assign dac_beat.last   = state_q == frame_second;

endmodule

// File: recorder/sample_recorder.sv
// ADC sample recorder
`timescale 1ns/100ps

module sample_recorder #(
  parameter int fifo_addr_width = 2
) (
  input  logic                clk,
  input  logic                rst_n,

  // adc stream in
  input  audio_pkg::sample_t  adc_data,
  input  logic                adc_valid,
  output logic                adc_ready,

  // control
  input  logic                rec_enable,   // level, record while high

  // sample memory write side
  input  logic                mem_full,
  output buffer_pkg::mem_wr_t mem_wr
);

  import audio_pkg::*;

  // -------------------------------------------------------------------------
  // ingest fifo signals
  // -------------------------------------------------------------------------
  logic    ing_push;      // adc transfer that is kept
  logic    ing_full;
  logic    ing_pop;       // head moves to memory
  logic    ing_empty;
  sample_t head_sample;

  // -------------------------------------------------------------------------
  // adc side
  // -------------------------------------------------------------------------

  // not recording, every beat is taken and dropped
  // recording, ready follows the fifo room
  assign adc_ready = !rec_enable || !ing_full;

  // transfer while recording, ready already covers the full case
  assign ing_push = adc_valid && adc_ready && rec_enable;

  // -------------------------------------------------------------------------
  // memory side
  // -------------------------------------------------------------------------

  // one sample per cycle while there is one and the ring has room
  assign ing_pop = !ing_empty && !mem_full;

  assign mem_wr.en   = ing_pop;
  assign mem_wr.data = head_sample;  // head is stable until popped

  // drains on its own, also after rec_enable drops
  sync_fifo #(
    .fifo_addr_width ( fifo_addr_width )
  ) ingest_fifo_i (
    .clk             ( clk             ), // input
    .rst_n           ( rst_n           ), // input

    // ingress
    .wr_en           ( ing_push        ), // input
    .wr_data         ( adc_data        ), // input
    .full            ( ing_full        ), // output

    // egress
    .rd_en           ( ing_pop         ), // input
    .rd_data         ( head_sample     ), // output
    .empty           ( ing_empty       ), // output

    // status, not needed here
    .fill_level      (                 )  // output
  );

  // latency adc to memory
  //   edge 1 sample lands in the fifo
  //   cycle after, head visible, written on edge 2 if the ring has room

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the audio recorder simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_audio_recorder -f vlog.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -qx "all tests passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: test/tb_audio_recorder.sv
// Audio recorder testbench
`timescale 1ns/100ps

module tb_audio_recorder;

  import audio_pkg::*;

  // ------------------------------------------------------------------------
  // test table
  // ------------------------------------------------------------------------
  localparam logic [1:0] bp_ready  = 2'd0;  // dac_ready always high
  localparam logic [1:0] bp_random = 2'd1;  // lfsr pattern
  localparam logic [1:0] bp_hold   = 2'd2;  // low until adc_ready falls

  localparam int num_tests   = 6;
  localparam int wait_limit  = 400;  // cycles per wait loop
  localparam int quiet_limit = 50;   // cycles an unpaired sample must stay put

  typedef struct packed {
    int         count;      // samples offered after the discard phase
    logic       rec;        // rec_enable while they are offered
    logic [1:0] mode;       // dac_ready pattern
    int         discard;    // samples offered with recording off first
    int         exp_beats;  // dac beats expected out
  } test_row_t;

  test_row_t test_table [num_tests] = '{
    '{6,  1'b1, bp_ready,  0, 6},
    '{4,  1'b1, bp_ready,  5, 4},
    '{6,  1'b0, bp_ready,  0, 0},
    '{40, 1'b1, bp_random, 0, 40},
    '{30, 1'b1, bp_hold,   0, 30},
    '{7,  1'b1, bp_ready,  0, 8}   // odd count so one more sample follows
  };
  string test_names [num_tests] = '{
    "record_six", "discard_first", "rec_off", "random_ready", "hold_release", "odd_tail"
  };

  // ------------------------------------------------------------------------
  // dut signals and tb state
  // ------------------------------------------------------------------------
  logic      clk        = 1'b0;
  logic      rst_n      = 1'b0;
  sample_t   adc_data   = '0;
  logic      adc_valid  = 1'b0;
  logic      adc_ready;
  logic      rec_enable = 1'b1;  // recording from the start
  dac_beat_t dac_beat;
  logic      dac_valid;
  logic      dac_ready  = 1'b1;

  logic [31:0] data_lfsr  = 32'h27ed6987;
  logic [31:0] ready_lfsr = 32'h27ed6987;
  logic [1:0]  bp_mode       = bp_ready;  // written at negedge only
  logic        ready_release = 1'b0;
  logic        stall_seen    = 1'b0;

  sample_t exp_q [$];            // reference owned by the monitor
  sample_t head_expected;
  int      beat_count     = 0;
  logic    expect_last    = 1'b0;
  int      monitor_errors = 0;
  int      check_errors   = 0;
  int      tests_passed   = 0;
  int      tests_failed   = 0;

  audio_recorder_top #(
    .mem_addr_width  ( buffer_pkg::default_mem_addr_width  ),
    .fifo_addr_width ( buffer_pkg::default_fifo_addr_width )
  ) dut_i (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .adc_data   ( adc_data   ),
    .adc_valid  ( adc_valid  ),
    .adc_ready  ( adc_ready  ),
    .rec_enable ( rec_enable ),
    .dac_beat   ( dac_beat   ),
    .dac_valid  ( dac_valid  ),
    .dac_ready  ( dac_ready  )
  );

  always #5 clk = ~clk;  // 10 ns period

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per sample bit
  task automatic next_sample(output sample_t value);
    for (int k = 0; k < sample_width; k++) begin
      data_lfsr = lfsr_next(data_lfsr);
      value     = {value[sample_width-2:0], data_lfsr[0]};
    end
  endtask

  // back-pressure pattern
  always @(posedge clk) begin
    case (bp_mode)
      bp_random: begin
        ready_lfsr = lfsr_next(ready_lfsr);
        dac_ready <= ready_lfsr[0];
      end
      bp_hold: dac_ready <= ready_release;
      default: dac_ready <= 1'b1;
    endcase
  end

  // ------------------------------------------------------------------------
  // monitor samples at negedge where values hold through the transfer edge
  // ------------------------------------------------------------------------
  always @(negedge clk) begin
    if (rst_n) begin
      if (adc_valid && adc_ready && rec_enable) exp_q.push_back(adc_data);  // kept sample
      if (dac_valid && dac_ready) begin
        beat_count = beat_count + 1;
        if (exp_q.size() == 0) begin
          $display("dac beat %h arrived with no recorded sample pending", dac_beat.sample);
          monitor_errors = monitor_errors + 1;
        end else begin
          head_expected = exp_q.pop_front();
          if (dac_beat.sample !== head_expected) begin
            $display("Mismatch dac_beat.sample expected %h got %h",
                     head_expected, dac_beat.sample);
            monitor_errors = monitor_errors + 1;
          end
        end
        if (dac_beat.last !== expect_last) begin
          $display("Mismatch dac_beat.last expected %h got %h", expect_last, dac_beat.last);
          monitor_errors = monitor_errors + 1;
        end
        expect_last = !expect_last;  // left, right, left...
      end
    end
  end

  // ------------------------------------------------------------------------
  // stimulus tasks
  // ------------------------------------------------------------------------
  task automatic drive_sample(input sample_t value);
    int waited;
    @(posedge clk);  // previous sample transfers here
    adc_valid <= 1'b1;
    adc_data  <= value;
    waited = 0;
    @(negedge clk);
    while (!adc_ready && waited < wait_limit) begin
      if (bp_mode == bp_hold && !ready_release) begin
        stall_seen    = 1'b1;  // chain is full so let the dac drain
        ready_release = 1'b1;
      end
      waited = waited + 1;
      @(negedge clk);
    end
    if (!adc_ready) begin
      $display("adc_ready stayed low for %0d cycles", wait_limit);
      check_errors = check_errors + 1;
    end
    if (!rec_enable && waited != 0) begin
      $display("adc_ready dropped while recording was off");
      check_errors = check_errors + 1;
    end
  endtask

  // also ends the pending adc transfer
  task automatic set_recording(input logic rec);
    @(posedge clk);
    adc_valid  <= 1'b0;
    rec_enable <= rec;
  endtask

  task automatic wait_pending(input int target);
    int waited;
    waited = 0;
    @(posedge clk);
    while (exp_q.size() > target && waited < wait_limit) begin
      waited = waited + 1;
      @(posedge clk);
    end
    if (exp_q.size() > target) begin
      $display("timed out with %0d recorded samples still pending", exp_q.size());
      check_errors = check_errors + 1;
    end
  endtask

  // the odd sample must wait for a partner
  task automatic check_quiet();
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < quiet_limit; n++) begin
      @(negedge clk);
      if (dac_valid) seen = 1'b1;
    end
    if (seen) begin
      $display("unpaired sample was presented without its partner");
      check_errors = check_errors + 1;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (check_errors + monitor_errors == errors_before) begin
      tests_passed = tests_passed + 1;
      $display("test %0s: pass", name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %0s: FAIL", name);
    end
  endtask

  task automatic run_test(input int idx);
    test_row_t row;
    int        errors_before;
    int        beats_before;
    sample_t   value;
    row           = test_table[idx];
    errors_before = check_errors + monitor_errors;
    @(negedge clk);
    bp_mode       = row.mode;
    ready_release = 1'b0;
    stall_seen    = 1'b0;
    beats_before  = beat_count;
    set_recording(1'b0);
    for (int i = 0; i < row.discard; i++) begin
      next_sample(value);
      drive_sample(value);
    end
    set_recording(row.rec);
    for (int i = 0; i < row.count; i++) begin
      next_sample(value);
      drive_sample(value);
    end
    set_recording(row.rec);
    @(negedge clk);
    if (row.mode == bp_hold && !stall_seen) begin
      $display("adc_ready never fell under back-pressure");
      check_errors = check_errors + 1;
    end
    ready_release = 1'b1;
    if (row.rec && (row.count % 2) == 1) begin
      wait_pending(1);
      check_quiet();
      next_sample(value);  // partner for the stranded sample
      drive_sample(value);
      set_recording(row.rec);
    end
    wait_pending(0);
    if (beat_count - beats_before != row.exp_beats) begin
      $display("Mismatch beat_count expected %h got %h",
               row.exp_beats, beat_count - beats_before);
      check_errors = check_errors + 1;
    end
    finish_test(test_names[idx], errors_before);
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial begin
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (dac_valid !== 1'b0) begin
      $display("Mismatch dac_valid expected %h got %h", 1'b0, dac_valid);
      check_errors = check_errors + 1;
    end
    if (adc_ready !== 1'b1) begin
      $display("Mismatch adc_ready expected %h got %h", 1'b1, adc_ready);
      check_errors = check_errors + 1;
    end
    finish_test("reset_state", 0);
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
             tests_passed + tests_failed, tests_passed, tests_failed,
             check_errors + monitor_errors);
    if (tests_failed == 0 && check_errors + monitor_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: verilog/audio_recorder_top.sv
// Audio record and playback top
`timescale 1ns/100ps

module audio_recorder_top #(
  parameter int mem_addr_width  = buffer_pkg::default_mem_addr_width,
  parameter int fifo_addr_width = buffer_pkg::default_fifo_addr_width
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // adc stream
  input  audio_pkg::sample_t   adc_data,
  input  logic                 adc_valid,
  output logic                 adc_ready,

  // control
  input  logic                 rec_enable,

  // dac stream, always playback
  output audio_pkg::dac_beat_t dac_beat,
  output logic                 dac_valid,
  input  logic                 dac_ready
);

  import buffer_pkg::*;

  // -------------------------------------------------------------------------
  // recorder to memory
  // -------------------------------------------------------------------------
  mem_wr_t mem_wr;
  logic    mem_full;

  // -------------------------------------------------------------------------
  // memory to player
  // -------------------------------------------------------------------------
  mem_rd_t mem_rd;
  logic    mem_empty;
  logic    mem_rd_en;

  sample_recorder #(
    .fifo_addr_width ( fifo_addr_width )
  ) sample_recorder_i (
    .clk        ( clk        ), // input
    .rst_n      ( rst_n      ), // input
    .adc_data   ( adc_data   ), // input
    .adc_valid  ( adc_valid  ), // input
    .adc_ready  ( adc_ready  ), // output
    .rec_enable ( rec_enable ), // input
    .mem_full   ( mem_full   ), // input
    .mem_wr     ( mem_wr     )  // output
  );

  sample_memory #(
    .mem_addr_width ( mem_addr_width )
  ) sample_memory_i (
    .clk    ( clk       ), // input
    .rst_n  ( rst_n     ), // input
    .mem_wr ( mem_wr    ), // input
    .full   ( mem_full  ), // output
    .rd_en  ( mem_rd_en ), // input
    .mem_rd ( mem_rd    ), // output
    .empty  ( mem_empty )  // output
  );

  sample_player #(
    .fifo_addr_width ( fifo_addr_width )
  ) sample_player_i (
    .clk       ( clk       ), // input
    .rst_n     ( rst_n     ), // input
    .mem_empty ( mem_empty ), // input
    .rd_en     ( mem_rd_en ), // output
    .mem_rd    ( mem_rd    ), // input
    .dac_beat  ( dac_beat  ), // output
    .dac_valid ( dac_valid ), // output
    .dac_ready ( dac_ready )  // input
  );

endmodule

// File: verilog/sample_memory.sv
// Ring buffer sample memory
`timescale 1ns/100ps

module sample_memory #(
  parameter int mem_addr_width = 4
) (
  input  logic                clk,
  input  logic                rst_n,

  // write port
  input  buffer_pkg::mem_wr_t mem_wr,
  output logic                full,

  // read port
  input  logic                rd_en,
  output buffer_pkg::mem_rd_t mem_rd,   // one cycle after rd_en
  output logic                empty
);

  import audio_pkg::*;

  localparam int depth = 2 ** mem_addr_width;

  typedef logic [mem_addr_width:0] ptr_t;  // address plus wrap bit

  sample_t ram [depth];

  ptr_t    wr_ptr_q;
  ptr_t    rd_ptr_q;
  logic    wr_go;
  logic    rd_go;
  logic    rd_valid_q;
  sample_t rd_data_q;

  // -------------------------------------------------------------------------
  // ring state, straight from the pointer registers
  // -------------------------------------------------------------------------
  assign empty = wr_ptr_q == rd_ptr_q;
  assign full  = (wr_ptr_q[mem_addr_width] != rd_ptr_q[mem_addr_width]) &&
                 (wr_ptr_q[mem_addr_width-1:0] == rd_ptr_q[mem_addr_width-1:0]);

  assign wr_go = mem_wr.en && !full;   // guarded again, callers check too
  assign rd_go = rd_en && !empty;

  // array and read data register
  // no address clash, a read never sees the slot being written
  always_ff @(posedge clk) begin
    if (wr_go) begin
      ram[wr_ptr_q[mem_addr_width-1:0]] <= mem_wr.data;
    end
    if (rd_go) begin
      rd_data_q <= ram[rd_ptr_q[mem_addr_width-1:0]];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_go;                 // single cycle strobe
      if (wr_go) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_go) rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  assign mem_rd.valid = rd_valid_q;
  assign mem_rd.data  = rd_data_q;

endmodule

// File: verilog/sync_fifo.sv
// Synchronous sample FIFO
`timescale 1ns/100ps

module sync_fifo #(
  parameter int fifo_addr_width = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,

  // ingress
  input  logic                     wr_en,
  input  audio_pkg::sample_t       wr_data,
  output logic                     full,

  // egress
  input  logic                     rd_en,
  output audio_pkg::sample_t       rd_data,     // head, valid while not empty
  output logic                     empty,

  // status
  output logic [fifo_addr_width:0] fill_level
);

  import audio_pkg::*;

  localparam int depth = 2 ** fifo_addr_width;

  typedef logic [fifo_addr_width:0] ptr_t;  // address plus wrap bit

  sample_t storage [depth];  // payload only, no reset

  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  logic push;
  logic pop;

  // guarded strobes, overflow and underflow are ignored
  assign push = wr_en && !full;
  assign pop  = rd_en && !empty;

  // -------------------------------------------------------------------------
  // flags from the pointer difference
  // -------------------------------------------------------------------------
  assign fill_level = wr_ptr_q - rd_ptr_q;   // wraps cleanly, extra bit
  assign full       = fill_level == ptr_t'(depth);
  assign empty      = wr_ptr_q == rd_ptr_q;

  // head is shown without a read strobe
  assign rd_data = storage[rd_ptr_q[fifo_addr_width-1:0]];

  // -------------------------------------------------------------------------
  // storage
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (push) begin
      storage[wr_ptr_q[fifo_addr_width-1:0]] <= wr_data;
    end
  end

  // -------------------------------------------------------------------------
  // pointers
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // wrap bit flips every depth writes
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

endmodule

// File: vlog.f
common/audio_pkg.sv
common/buffer_pkg.sv
verilog/sync_fifo.sv
recorder/sample_recorder.sv
verilog/sample_memory.sv
player/sample_player.sv
verilog/audio_recorder_top.sv
test/tb_audio_recorder.sv
